/* design/axil_data_port.sv */
`include "rv_be_consts.svh"

module axil_data_port (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  rv_be_pkg::mem_item_t   in_item_i,

    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output rv_be_pkg::wbin_item_t  out_item_o,

    output logic [`RV_AXI_AW-1:0]  m_axil_awaddr_o,
    output logic                   m_axil_awvalid_o,
    input  logic                   m_axil_awready_i,
    output logic [`RV_XLEN-1:0]    m_axil_wdata_o,
    output logic [3:0]             m_axil_wstrb_o,
    output logic                   m_axil_wvalid_o,
    input  logic                   m_axil_wready_i,
    input  logic [1:0]             m_axil_bresp_i,
    input  logic                   m_axil_bvalid_i,
    output logic                   m_axil_bready_o,
    output logic [`RV_AXI_AW-1:0]  m_axil_araddr_o,
    output logic                   m_axil_arvalid_o,
    input  logic                   m_axil_arready_i,
    input  logic [`RV_XLEN-1:0]    m_axil_rdata_i,
    input  logic [1:0]             m_axil_rresp_i,
    input  logic                   m_axil_rvalid_i,
    output logic                   m_axil_rready_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_RESP = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]           state;
    logic                 aw_pend, w_pend, ar_pend;
    logic                 addr_left;
    logic                 accept, issue, resp_seen;
    rv_be_pkg::mem_item_t item_q;
    logic [`RV_XLEN-1:0]  rdata_q;

    assign in_ready_o  = (state == ST_IDLE) || (state == ST_DONE && out_ready_i);
    assign out_valid_o = state == ST_DONE;
    assign accept      = in_valid_i && in_ready_o;
    assign issue       = (in_item_i.is_load || in_item_i.is_store) && !in_item_i.misaligned;
    assign addr_left   = (aw_pend && !m_axil_awready_i) || (w_pend && !m_axil_wready_i) ||
                         (ar_pend && !m_axil_arready_i);
    assign resp_seen   = item_q.is_store ? m_axil_bvalid_i : m_axil_rvalid_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            ar_pend <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (accept && issue) begin
                        state   <= ST_ADDR;
                        aw_pend <= in_item_i.is_store;   // AW and W together.
                        w_pend  <= in_item_i.is_store;
                        ar_pend <= in_item_i.is_load;
                    end else if (accept) begin
                        state <= ST_DONE;                // Bypass the bus.
                    end else if (out_ready_i) begin
                        state <= ST_IDLE;
                    end
                end
                ST_ADDR: begin
                    if (m_axil_awready_i) aw_pend <= 1'b0;
                    if (m_axil_wready_i)  w_pend  <= 1'b0;
                    if (m_axil_arready_i) ar_pend <= 1'b0;
                    if (!addr_left) state <= ST_RESP;
                end
                default: begin
                    if (resp_seen) state <= ST_DONE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            item_q <= in_item_i;
        end
        if (m_axil_rvalid_i && m_axil_rready_o) begin
            rdata_q <= m_axil_rdata_i;
        end
    end

    //////////////////////////////
    // Bus drive
    //////////////////////////////

    assign m_axil_awaddr_o  = item_q.addr;
    assign m_axil_awvalid_o = aw_pend;
    assign m_axil_wdata_o   = item_q.wdata;
    assign m_axil_wstrb_o   = item_q.wstrb;
    assign m_axil_wvalid_o  = w_pend;
    assign m_axil_araddr_o  = item_q.addr;
    assign m_axil_arvalid_o = ar_pend;
    assign m_axil_bready_o  = (state == ST_RESP) && item_q.is_store;
    assign m_axil_rready_o  = (state == ST_RESP) && item_q.is_load;

    always_comb begin
        out_item_o.instr      = item_q.instr;
        out_item_o.pc         = item_q.pc;
        out_item_o.alu_result = item_q.alu_result;
        out_item_o.rdata      = rdata_q;
        out_item_o.is_load    = item_q.is_load;
        out_item_o.misaligned = item_q.misaligned;
    end

    // Error responses are not handled.
    a_bresp_okay: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_axil_bvalid_i && m_axil_bready_o |-> m_axil_bresp_i == 2'b00);
    a_rresp_okay: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_axil_rvalid_i && m_axil_rready_o |-> m_axil_rresp_i == 2'b00);
    a_one_txn: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(m_axil_awvalid_o && m_axil_arvalid_o));

endmodule

/* design/load_writeback_stage.sv */
`include "rv_be_consts.svh"

module load_writeback_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  rv_be_pkg::wbin_item_t  in_item_i,

    output rv_be_pkg::wb_item_t    wb_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] lane;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] result;
    logic                we_d;

    logic                retire_q, we_q, mis_q;
    logic [4:0]          rd_q;
    logic [`RV_XLEN-1:0] data_q, pc_q;

    assign in_ready_o = 1'b1;
    assign opcode     = in_item_i.instr.r.opcode;
    assign funct3     = in_item_i.instr.r.funct3;
    assign rd         = in_item_i.instr.r.rd;

    // Byte or halfword down to bit 0.
    assign lane = in_item_i.rdata >> {in_item_i.alu_result[1:0], 3'b000};

    always_comb begin
        case (funct3)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};     // LB
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};   // LH
            3'b100:  load_data = {24'h0, lane[7:0]};             // LBU
            3'b101:  load_data = {16'h0, lane[15:0]};            // LHU
            default: load_data = lane;
        endcase
    end

    assign result = (in_item_i.is_load && !in_item_i.misaligned) ? load_data
                                                                 : in_item_i.alu_result;

    always_comb begin
        case (opcode)
            `RV_OP_RTYPE, `RV_OP_IMM, `RV_OP_LUI, `RV_OP_AUIPC,
            `RV_OP_JAL, `RV_OP_JALR: we_d = 1'b1;
            `RV_OP_LOAD:             we_d = !in_item_i.misaligned;
            `RV_OP_SYSTEM:           we_d = |funct3;     // CSR ops only.
            default:                 we_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_q <= 1'b0;
            we_q     <= 1'b0;
        end else begin
            retire_q <= in_valid_i;
            we_q     <= in_valid_i && we_d && (|rd);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            rd_q   <= rd;
            data_q <= result;
            pc_q   <= in_item_i.pc;
            mis_q  <= in_item_i.misaligned;
        end
    end

    always_comb begin
        wb_o.retire     = retire_q;
        wb_o.we         = we_q;
        wb_o.rd         = rd_q;
        wb_o.data       = data_q;
        wb_o.pc         = pc_q;
        wb_o.misaligned = mis_q;
    end

endmodule

/* design/mem_request_stage.sv */
`include "rv_be_consts.svh"

module mem_request_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  rv_be_pkg::ex_item_t   in_item_i,

    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output rv_be_pkg::mem_item_t  out_item_o
);

    logic                 valid_q;
    rv_be_pkg::mem_item_t item_q;
    rv_be_pkg::mem_item_t item_d;

    logic                 is_load;
    logic                 is_store;
    logic [1:0]           size;
    logic [1:0]           byte_off;
    logic [3:0]           strb_base;
    logic                 bad_align;

    //////////////////////////////
    // Decode and lane placement
    //////////////////////////////

    assign is_load  = in_item_i.instr.r.opcode == `RV_OP_LOAD;
    assign is_store = in_item_i.instr.s.opcode == `RV_OP_STORE;
    assign size     = in_item_i.instr.s.funct3[1:0];
    assign byte_off = in_item_i.alu_result[1:0];

    always_comb begin
        case (size)
            2'b00: begin
                strb_base = 4'b0001;
                bad_align = 1'b0;
            end
            2'b01: begin
                strb_base = 4'b0011;
                bad_align = byte_off[0];     // Odd halfword.
            end
            default: begin
                strb_base = 4'b1111;
                bad_align = |byte_off;
            end
        endcase
    end

    always_comb begin
        item_d.instr      = in_item_i.instr;
        item_d.pc         = in_item_i.pc;
        item_d.alu_result = in_item_i.alu_result;
        item_d.is_load    = is_load;
        item_d.is_store   = is_store;
        item_d.misaligned = (is_load || is_store) && bad_align;
        item_d.addr       = in_item_i.alu_result;
        item_d.wdata      = in_item_i.store_data << {byte_off, 3'b000};
        item_d.wstrb      = (is_store && !bad_align) ? strb_base << byte_off : 4'b0000;
    end

    //////////////////////////////
    // Single slot
    //////////////////////////////

    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign out_item_o  = item_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            item_q <= item_d;
        end
    end

    // Stalled output must not change.
    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_item_o));

endmodule

/* design/rv_backend_top.sv */
`include "rv_be_consts.svh"

module rv_backend_top (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  logic                   ex_valid_i,
    output logic                   ex_ready_o,
    input  rv_be_pkg::ex_item_t    ex_item_i,

    output logic [`RV_AXI_AW-1:0]  m_axil_awaddr_o,
    output logic                   m_axil_awvalid_o,
    input  logic                   m_axil_awready_i,
    output logic [`RV_XLEN-1:0]    m_axil_wdata_o,
    output logic [3:0]             m_axil_wstrb_o,
    output logic                   m_axil_wvalid_o,
    input  logic                   m_axil_wready_i,
    input  logic [1:0]             m_axil_bresp_i,
    input  logic                   m_axil_bvalid_i,
    output logic                   m_axil_bready_o,
    output logic [`RV_AXI_AW-1:0]  m_axil_araddr_o,
    output logic                   m_axil_arvalid_o,
    input  logic                   m_axil_arready_i,
    input  logic [`RV_XLEN-1:0]    m_axil_rdata_i,
    input  logic [1:0]             m_axil_rresp_i,
    input  logic                   m_axil_rvalid_i,
    output logic                   m_axil_rready_o,

    output rv_be_pkg::wb_item_t    wb_o
);

    logic                  req_valid, req_ready;
    rv_be_pkg::mem_item_t  req_item;
    logic                  wbin_valid, wbin_ready;
    rv_be_pkg::wbin_item_t wbin_item;

    //////////////////////////////
    // EX -> MEM -> WB chain
    //////////////////////////////

    mem_request_stage i_mem_req (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (ex_valid_i),
        .in_ready_o  (ex_ready_o),
        .in_item_i   (ex_item_i),
        .out_valid_o (req_valid),
        .out_ready_i (req_ready),
        .out_item_o  (req_item)
    );

    axil_data_port i_data_port (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .in_valid_i       (req_valid),
        .in_ready_o       (req_ready),
        .in_item_i        (req_item),
        .out_valid_o      (wbin_valid),
        .out_ready_i      (wbin_ready),
        .out_item_o       (wbin_item),
        .m_axil_awaddr_o  (m_axil_awaddr_o),
        .m_axil_awvalid_o (m_axil_awvalid_o),
        .m_axil_awready_i (m_axil_awready_i),
        .m_axil_wdata_o   (m_axil_wdata_o),
        .m_axil_wstrb_o   (m_axil_wstrb_o),
        .m_axil_wvalid_o  (m_axil_wvalid_o),
        .m_axil_wready_i  (m_axil_wready_i),
        .m_axil_bresp_i   (m_axil_bresp_i),
        .m_axil_bvalid_i  (m_axil_bvalid_i),
        .m_axil_bready_o  (m_axil_bready_o),
        .m_axil_araddr_o  (m_axil_araddr_o),
        .m_axil_arvalid_o (m_axil_arvalid_o),
        .m_axil_arready_i (m_axil_arready_i),
        .m_axil_rdata_i   (m_axil_rdata_i),
        .m_axil_rresp_i   (m_axil_rresp_i),
        .m_axil_rvalid_i  (m_axil_rvalid_i),
        .m_axil_rready_o  (m_axil_rready_o)
    );

    load_writeback_stage i_wb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .in_valid_i (wbin_valid),
        .in_ready_o (wbin_ready),
        .in_item_i  (wbin_item),
        .wb_o       (wb_o)
    );

endmodule

/* design/rv_be_consts.svh */
`ifndef RV_BE_CONSTS_SVH
`define RV_BE_CONSTS_SVH

// RV32I major opcodes.
`define RV_OP_RTYPE  7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_SYSTEM 7'b1110011
`define RV_OP_BRANCH 7'b1100011

// Datapath and bus widths.
`define RV_XLEN   32
`define RV_AXI_AW 32

`endif

/* design/rv_be_pkg.sv */
`include "rv_be_consts.svh"

package rv_be_pkg;

    // Formats with an rd field.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rd_fmt_t;

    // S-type, immediate split around rs1/rs2.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } st_fmt_t;

    typedef union packed {
        rd_fmt_t r;
        st_fmt_t s;
    } instr_u;

    //////////////////////////////
    // Stage bundles
    //////////////////////////////

    typedef struct packed {
        instr_u               instr;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  alu_result;
        logic [`RV_XLEN-1:0]  store_data;
    } ex_item_t;

    typedef struct packed {
        instr_u                instr;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   alu_result;
        logic                  is_load;
        logic                  is_store;
        logic                  misaligned;
        logic [`RV_AXI_AW-1:0] addr;
        logic [`RV_XLEN-1:0]   wdata;
        logic [3:0]            wstrb;
    } mem_item_t;

    typedef struct packed {
        instr_u               instr;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  alu_result;
        logic [`RV_XLEN-1:0]  rdata;      // Raw memory word.
        logic                 is_load;
        logic                 misaligned;
    } wbin_item_t;

    typedef struct packed {
        logic                 retire;
        logic                 we;
        logic [4:0]           rd;
        logic [`RV_XLEN-1:0]  data;
        logic [`RV_XLEN-1:0]  pc;
        logic                 misaligned;
    } wb_item_t;

endpackage

/* flist.f */
+incdir+design
design/rv_be_pkg.sv
design/mem_request_stage.sv
design/axil_data_port.sv
design/load_writeback_stage.sv
design/rv_backend_top.sv
test/axil_mem_model.sv
test/tb_rv_backend.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f flist.f \
    --top-module tb_rv_backend \
    -o sim_tb_rv_backend

./obj_dir/sim_tb_rv_backend

/* test/axil_mem_model.sv */
module axil_mem_model (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [64];
    logic [15:0] lfsr;
    logic        aw_ok, w_ok, ar_ok;
    logic [5:0]  waddr, raddr;
    logic [31:0] wdat;
    logic [3:0]  wstb;
    logic [1:0]  wait_cnt;

    assign bresp_o = 2'b00;
    assign rresp_o = 2'b00;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit drawn.
    task automatic draw_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] <= 32'h5a00_0000 ^ (i * 32'h0103_0507);   // Unique per word.
        end
    end

    ////////////////////////////////
    // Slave channels
    ////////////////////////////////

    always @(posedge clk) begin : bus
        logic b0;
        logic b1;
        if (!rst_n_i) begin
            lfsr = 16'd54744;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            arready_o <= 1'b0;
            bvalid_o  <= 1'b0;
            rvalid_o  <= 1'b0;
            aw_ok     <= 1'b0;
            w_ok      <= 1'b0;
            ar_ok     <= 1'b0;
            wait_cnt  <= 2'd0;
        end else begin
            draw_bit(b0);
            awready_o <= b0;
            draw_bit(b0);
            wready_o <= b0;
            draw_bit(b0);
            arready_o <= b0;
            if (bvalid_o && bready_i) bvalid_o <= 1'b0;
            if (rvalid_o && rready_i) rvalid_o <= 1'b0;
            if ((awvalid_i && awready_o) || (arvalid_i && arready_o)) begin
                draw_bit(b0);
                draw_bit(b1);
                wait_cnt <= {b1, b0};                      // Response delay 0..3.
            end
            if (awvalid_i && awready_o) begin
                aw_ok <= 1'b1;
                waddr <= awaddr_i[7:2];
            end
            if (wvalid_i && wready_o) begin
                w_ok <= 1'b1;
                wdat <= wdata_i;
                wstb <= wstrb_i;
            end
            if (arvalid_i && arready_o) begin
                ar_ok <= 1'b1;
                raddr <= araddr_i[7:2];
            end
            if ((aw_ok && w_ok) || ar_ok) begin
                if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else if (aw_ok && w_ok) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstb[b]) mem[waddr][8*b +: 8] <= wdat[8*b +: 8];
                    end
                    bvalid_o <= 1'b1;
                    aw_ok    <= 1'b0;
                    w_ok     <= 1'b0;
                end else begin
                    rdata_o  <= mem[raddr];
                    rvalid_o <= 1'b1;
                    ar_ok    <= 1'b0;
                end
            end
        end
    end

endmodule

/* test/tb_rv_backend.sv */
`include "rv_be_consts.svh"

module tb_rv_backend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_ROWS = 48;

    logic                  clk;
    logic                  rst_n_i;
    logic                  ex_valid_i;
    logic                  ex_ready_o;
    rv_be_pkg::ex_item_t   ex_item_i;
    rv_be_pkg::wb_item_t   wb_o;

    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;

    // Stimulus and expected results, one row per instruction.
    string               row_name [MAX_ROWS];
    rv_be_pkg::ex_item_t row_item [MAX_ROWS];
    logic                exp_we   [MAX_ROWS];
    logic [4:0]          exp_rd   [MAX_ROWS];
    logic [31:0]         exp_data [MAX_ROWS];
    logic                exp_mis  [MAX_ROWS];
    int                  row_count;
    int                  retired;
    int                  cycles;
    int                  last_retire;
    int                  txn_count;
    int                  exp_txn;

    rv_backend_top i_dut (
        .clk(clk), .rst_n_i(rst_n_i),
        .ex_valid_i(ex_valid_i), .ex_ready_o(ex_ready_o), .ex_item_i(ex_item_i),
        .m_axil_awaddr_o(awaddr), .m_axil_awvalid_o(awvalid), .m_axil_awready_i(awready),
        .m_axil_wdata_o(wdata), .m_axil_wstrb_o(wstrb), .m_axil_wvalid_o(wvalid),
        .m_axil_wready_i(wready), .m_axil_bresp_i(bresp), .m_axil_bvalid_i(bvalid),
        .m_axil_bready_o(bready), .m_axil_araddr_o(araddr), .m_axil_arvalid_o(arvalid),
        .m_axil_arready_i(arready), .m_axil_rdata_i(rdata), .m_axil_rresp_i(rresp),
        .m_axil_rvalid_i(rvalid), .m_axil_rready_o(rready), .wb_o(wb_o)
    );

    axil_mem_model i_mem (
        .clk(clk), .rst_n_i(rst_n_i),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
        .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready)
    );

    always #20 clk = ~clk;

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s (%s) expected %h actual %h", test, field, exp, act);
            $display("** FAIL **");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic rv_be_pkg::instr_u encode_instr(input logic [6:0] op,
                                                       input logic [2:0] f3,
                                                       input logic [4:0] rd);
        rv_be_pkg::instr_u u;
        u          = '0;
        u.r.opcode = op;
        u.r.funct3 = f3;
        u.r.rd     = rd;
        u.r.rs1    = 5'd10;
        return u;
    endfunction

    task automatic add_row(input string name, input logic [6:0] op, input logic [2:0] f3,
                           input logic [4:0] rd, input logic [31:0] alu,
                           input logic [31:0] sdata, input logic we,
                           input logic [31:0] data, input logic mis);
        row_name[row_count]            = name;
        row_item[row_count].instr      = encode_instr(op, f3, rd);
        row_item[row_count].pc         = 32'h1000 + 4 * row_count;
        row_item[row_count].alu_result = alu;
        row_item[row_count].store_data = sdata;
        exp_we[row_count]              = we;
        exp_rd[row_count]              = rd;
        exp_data[row_count]            = data;
        exp_mis[row_count]             = mis;
        row_count++;
    endtask

    ////////////////////////////////
    // Table
    ////////////////////////////////

    task automatic build_table();
        add_row("add", `RV_OP_RTYPE, 3'd0, 5'd1, 32'h1111_1111, 0, 1, 32'h1111_1111, 0);
        add_row("addi", `RV_OP_IMM, 3'd0, 5'd2, 32'h2222_2222, 0, 1, 32'h2222_2222, 0);
        add_row("lui", `RV_OP_LUI, 3'd0, 5'd3, 32'h1234_5000, 0, 1, 32'h1234_5000, 0);
        add_row("auipc", `RV_OP_AUIPC, 3'd0, 5'd4, 32'h0040_1000, 0, 1, 32'h0040_1000, 0);
        add_row("jal", `RV_OP_JAL, 3'd0, 5'd5, 32'h0000_0104, 0, 1, 32'h0000_0104, 0);
        add_row("jalr", `RV_OP_JALR, 3'd0, 5'd6, 32'h0000_0208, 0, 1, 32'h0000_0208, 0);
        add_row("csrrw", `RV_OP_SYSTEM, 3'd1, 5'd7, 32'h0000_c5c5, 0, 1, 32'h0000_c5c5, 0);
        add_row("addi_x0", `RV_OP_IMM, 3'd0, 5'd0, 32'h0000_0777, 0, 0, 32'h0000_0777, 0);
        add_row("ecall", `RV_OP_SYSTEM, 3'd0, 5'd8, 32'h0000_0abc, 0, 0, 32'h0000_0abc, 0);
        add_row("beq", `RV_OP_BRANCH, 3'd0, 5'd8, 32'h0000_0001, 0, 0, 32'h0000_0001, 0);
        // Byte-strobe merge into word 0x40.
        add_row("sw_40", `RV_OP_STORE, 3'd2, 5'd0, 32'h40, 32'h1122_3344, 0, 32'h40, 0);
        add_row("sh_42", `RV_OP_STORE, 3'd1, 5'd0, 32'h42, 32'h0000_beef, 0, 32'h42, 0);
        add_row("sb_41", `RV_OP_STORE, 3'd0, 5'd0, 32'h41, 32'h0000_005a, 0, 32'h41, 0);
        add_row("lw_40", `RV_OP_LOAD, 3'd2, 5'd9, 32'h40, 0, 1, 32'hbeef_5a44, 0);
        add_row("sw_44", `RV_OP_STORE, 3'd2, 5'd0, 32'h44, 32'h8091_a2f3, 0, 32'h44, 0);
        add_row("sw_48", `RV_OP_STORE, 3'd2, 5'd0, 32'h48, 32'h7f01_6c05, 0, 32'h48, 0);
        add_row("lb_44", `RV_OP_LOAD, 3'd0, 5'd11, 32'h44, 0, 1, 32'hffff_fff3, 0);
        add_row("lb_45", `RV_OP_LOAD, 3'd0, 5'd12, 32'h45, 0, 1, 32'hffff_ffa2, 0);
        add_row("lb_46", `RV_OP_LOAD, 3'd0, 5'd13, 32'h46, 0, 1, 32'hffff_ff91, 0);
        add_row("lb_47", `RV_OP_LOAD, 3'd0, 5'd14, 32'h47, 0, 1, 32'hffff_ff80, 0);
        add_row("lbu_44", `RV_OP_LOAD, 3'd4, 5'd15, 32'h44, 0, 1, 32'h0000_00f3, 0);
        add_row("lbu_45", `RV_OP_LOAD, 3'd4, 5'd16, 32'h45, 0, 1, 32'h0000_00a2, 0);
        add_row("lbu_46", `RV_OP_LOAD, 3'd4, 5'd17, 32'h46, 0, 1, 32'h0000_0091, 0);
        add_row("lbu_47", `RV_OP_LOAD, 3'd4, 5'd18, 32'h47, 0, 1, 32'h0000_0080, 0);
        add_row("lh_44", `RV_OP_LOAD, 3'd1, 5'd19, 32'h44, 0, 1, 32'hffff_a2f3, 0);
        add_row("lh_46", `RV_OP_LOAD, 3'd1, 5'd20, 32'h46, 0, 1, 32'hffff_8091, 0);
        add_row("lhu_44", `RV_OP_LOAD, 3'd5, 5'd21, 32'h44, 0, 1, 32'h0000_a2f3, 0);
        add_row("lhu_46", `RV_OP_LOAD, 3'd5, 5'd22, 32'h46, 0, 1, 32'h0000_8091, 0);
        add_row("lb_48", `RV_OP_LOAD, 3'd0, 5'd23, 32'h48, 0, 1, 32'h0000_0005, 0);
        add_row("lh_4a", `RV_OP_LOAD, 3'd1, 5'd24, 32'h4a, 0, 1, 32'h0000_7f01, 0);
        // Misaligned accesses never reach the bus.
        add_row("sw_50", `RV_OP_STORE, 3'd2, 5'd0, 32'h50, 32'hcafe_f00d, 0, 32'h50, 0);
        add_row("sw_51", `RV_OP_STORE, 3'd2, 5'd0, 32'h51, 32'hffff_ffff, 0, 32'h51, 1);
        add_row("sh_53", `RV_OP_STORE, 3'd1, 5'd0, 32'h53, 32'h0000_ffff, 0, 32'h53, 1);
        add_row("lh_55", `RV_OP_LOAD, 3'd1, 5'd25, 32'h55, 0, 0, 32'h55, 1);
        add_row("lw_52", `RV_OP_LOAD, 3'd2, 5'd26, 32'h52, 0, 0, 32'h52, 1);
        add_row("lw_50", `RV_OP_LOAD, 3'd2, 5'd27, 32'h50, 0, 1, 32'hcafe_f00d, 0);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 20 * row_count + 100) begin
            $display("Timeout: only %0d of %0d instructions retired", retired, row_count);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // Address handshakes seen on the bus.
    always @(posedge clk) begin
        if (rst_n_i && awvalid && awready) begin
            txn_count = txn_count + 1;
        end
        if (rst_n_i && arvalid && arready) begin
            txn_count = txn_count + 1;
        end
    end

    // Retire checker. Outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (rst_n_i && wb_o.retire) begin
            if (retired >= row_count) begin
                $display("An instruction retired beyond the end of the table");
                $display("** FAIL **");
                $fatal(1, "extra retire");
            end
            check_field(row_name[retired], "pc", row_item[retired].pc, wb_o.pc);
            check_field(row_name[retired], "we", 32'(exp_we[retired]), 32'(wb_o.we));
            check_field(row_name[retired], "rd", 32'(exp_rd[retired]), 32'(wb_o.rd));
            check_field(row_name[retired], "data", exp_data[retired], wb_o.data);
            check_field(row_name[retired], "misaligned", 32'(exp_mis[retired]),
                        32'(wb_o.misaligned));
            // Only aligned loads and stores use the bus.
            if ((row_item[retired].instr.r.opcode == `RV_OP_LOAD ||
                 row_item[retired].instr.r.opcode == `RV_OP_STORE) && !exp_mis[retired]) begin
                exp_txn++;
            end
            check_field(row_name[retired], "axi txns", exp_txn, txn_count);
            if (retired > 0 && retired < 10) begin
                check_field(row_name[retired], "retire cycle", last_retire + 1, cycles);
            end
            last_retire = cycles;
            retired++;
        end
    end

    initial begin
        logic hs;
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        ex_valid_i = 1'b0;
        ex_item_i  = '0;
        cycles     = 0;
        retired    = 0;
        row_count  = 0;
        txn_count  = 0;
        exp_txn    = 0;
        build_table();
        repeat (8) @(posedge clk);
        #2 rst_n_i = 1'b1;
        for (int r = 0; r < row_count; r++) begin
            ex_valid_i = 1'b1;
            ex_item_i  = row_item[r];
            do begin
                @(negedge clk);
                hs = ex_ready_o;
                @(posedge clk);
            end while (!hs);
            #2;
        end
        ex_valid_i = 1'b0;
        wait (retired == row_count);
        repeat (4) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule
